//--- rv_exec_top.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_issue_ctrl.sv
hw/rv_exec_top.sv
test/rv_exec_tb.sv

//--- test/rv_exec_tb.sv
/*
 * Testbench for the execute unit
 * clock and reset, random instruction stimulus over req/ack,
 * shadow register model and concurrent checks on commit and handshake
 */
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_exec_tb;

  localparam int N_INIT = 62;
  localparam int N_RAND = 300;
  // a transaction takes at most 7 cycles, the rest is margin
  localparam int MAX_CYCLES = (N_INIT + N_RAND) * 10 + 200;

  logic                 clk;
  logic                 rst;
  logic                 req;
  rv_isa_pkg::instr_t   instr;
  logic                 ack;
  rv_core_pkg::commit_t commit;

  int                   seed = 32'h1543c2e0;
  int                   cycle_count = 0;
  int                   err_count = 0;
  logic                 seen_req = 1'b0;
  logic [`XLEN-1:0]     shadow [0:31];
  logic [`REG_AW-1:0]   last_rd = '0;

  // expected commit of the transaction in flight
  logic [`REG_AW-1:0]   exp_rd = '0;
  logic [`XLEN-1:0]     exp_wdata = '0;
  logic                 exp_we = 1'b0;
  logic                 exp_illegal = 1'b0;

  rv_exec_top uut (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .instr  (instr),
    .ack    (ack),
    .commit (commit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_and_stop(input string line);
    err_count++;
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      fail_and_stop($sformatf("timeout: run still busy after %0d cycles", MAX_CYCLES));
    end
  end

  // expected result straight from the instruction encoding
  task automatic predict(input rv_isa_pkg::instr_t ins, output logic legal,
                         output logic [`XLEN-1:0] value);
    logic [`XLEN-1:0]        a;
    logic [`XLEN-1:0]        b;
    logic [`XLEN-1:0]        imm;
    logic signed [`XLEN-1:0] a_s;
    a     = shadow[ins.rs1];
    b     = shadow[ins.rs2];
    a_s   = a;
    imm   = {{(`XLEN-12){ins.funct7[6]}}, ins.funct7, ins.rs2};
    legal = 1'b1;
    value = '0;
    case (ins.opcode)
      rv_isa_pkg::OP: begin
        case ({ins.funct7, ins.funct3})
          {7'h00, 3'b000}: value = a + b;
          {7'h20, 3'b000}: value = a - b;
          {7'h00, 3'b111}: value = a & b;
          {7'h00, 3'b110}: value = a | b;
          {7'h00, 3'b100}: value = a ^ b;
          {7'h00, 3'b010}: value = ($signed(a) < $signed(b)) ? 1 : 0;
          {7'h00, 3'b011}: value = (a < b) ? 1 : 0;
          {7'h00, 3'b001}: value = a << b[4:0];
          {7'h00, 3'b101}: value = a >> b[4:0];
          {7'h20, 3'b101}: value = a_s >>> b[4:0];
          default:         legal = 1'b0;
        endcase
      end
      rv_isa_pkg::OP_IMM: begin
        case (ins.funct3)
          3'b000:  value = a + imm;
          3'b111:  value = a & imm;
          3'b110:  value = a | imm;
          3'b100:  value = a ^ imm;
          3'b010:  value = ($signed(a) < $signed(imm)) ? 1 : 0;
          default: legal = 1'b0;
        endcase
      end
      rv_isa_pkg::LUI: value = {ins.funct7, ins.rs2, ins.rs1, ins.funct3, 12'b0};
      default:         legal = 1'b0;
    endcase
  endtask

  // one full four-phase handshake, entered and left on a falling edge
  task automatic run_transaction(input logic [`XLEN-1:0] word);
    rv_isa_pkg::instr_t ins;
    logic               legal;
    logic [`XLEN-1:0]   value;
    int                 extra;
    ins = word;
    predict(ins, legal, value);
    exp_rd      = ins.rd;
    exp_wdata   = value;
    exp_illegal = !legal;
    exp_we      = legal && (ins.rd != '0);
    if (exp_we) begin
      shadow[ins.rd] = value;
    end
    last_rd  = ins.rd;
    instr    = ins;
    req      = 1'b1;
    seen_req = 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    extra = $unsigned($random(seed)) % 4;
    repeat (extra) @(negedge clk);
    req = 1'b0;
    @(negedge clk);
    while (ack) @(negedge clk);
    // RELEASE lasts one cycle before IDLE
    @(negedge clk);
  endtask

  task automatic random_word(output logic [`XLEN-1:0] word);
    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [11:0]        imm12;
    logic [19:0]        imm20;
    logic [6:0]         f7;
    logic [2:0]         f3;
    int                 kind;
    int                 pick;
    rd    = $random(seed);
    rs1   = $random(seed);
    rs2   = $random(seed);
    imm12 = $random(seed);
    imm20 = $random(seed);
    // chain on the previous destination now and then
    if ($unsigned($random(seed)) % 3 == 0) rs1 = last_rd;
    if ($unsigned($random(seed)) % 8 == 0) rd = '0;
    kind = $unsigned($random(seed)) % 16;
    pick = $unsigned($random(seed)) % 10;
    f7   = 7'h00;
    if (kind < 7) begin
      case (pick)
        0: f3 = 3'b000;
        1: begin
          f7 = 7'h20;
          f3 = 3'b000;
        end
        2: f3 = 3'b111;
        3: f3 = 3'b110;
        4: f3 = 3'b100;
        5: f3 = 3'b010;
        6: f3 = 3'b011;
        7: f3 = 3'b001;
        8: f3 = 3'b101;
        default: begin
          f7 = 7'h20;
          f3 = 3'b101;
        end
      endcase
      word = {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
    end else if (kind < 11) begin
      case (pick % 5)
        0: f3 = 3'b000;
        1: f3 = 3'b111;
        2: f3 = 3'b110;
        3: f3 = 3'b100;
        default: f3 = 3'b010;
      endcase
      word = {imm12, rs1, f3, rd, rv_isa_pkg::OP_IMM};
    end else if (kind < 13) begin
      word = {imm20, rd, rv_isa_pkg::LUI};
    end else begin
      // load opcode, M-extension funct7, SLLI, bad funct7 on AND
      case (pick % 4)
        0: word = {imm12, rs1, 3'b010, rd, 7'b0000011};
        1: word = {7'h01, rs2, rs1, 3'b000, rd, rv_isa_pkg::OP};
        2: word = {7'h00, rs2, rs1, 3'b001, rd, rv_isa_pkg::OP_IMM};
        default: word = {7'h20, rs2, rs1, 3'b111, rd, rv_isa_pkg::OP};
      endcase
    end
  endtask

  idle_after_reset: assert property (@(posedge clk) disable iff (rst)
    !seen_req |-> (!ack && (commit == '0))
  ) else fail_and_stop($sformatf("[FAIL] %0t: ack or commit set before first req", $time));

  commit_matches: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> (commit.rd == exp_rd) && (commit.we == exp_we) &&
                   (commit.illegal == exp_illegal) && (exp_illegal || (commit.wdata == exp_wdata))
  ) else fail_and_stop($sformatf(
    "[FAIL] %0t: commit rd %0d we %b illegal %b wdata %h, expected %0d %b %b %h", $time,
    commit.rd, commit.we, commit.illegal, commit.wdata,
    exp_rd, exp_we, exp_illegal, exp_wdata));

  ack_two_cycles: assert property (@(posedge clk) disable iff (rst)
    $rose(req) |-> !ack ##1 !ack ##1 ack
  ) else fail_and_stop($sformatf("[FAIL] %0t: ack not 2 cycles after req", $time));

  ack_held: assert property (@(posedge clk) disable iff (rst)
    (ack && req) |=> (ack && $stable(commit))
  ) else fail_and_stop($sformatf("[FAIL] %0t: ack or commit moved while req held", $time));

  ack_release: assert property (@(posedge clk) disable iff (rst)
    (ack && !req) |=> !ack
  ) else fail_and_stop($sformatf("[FAIL] %0t: ack did not fall after req low", $time));

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req)
  ) else fail_and_stop($sformatf("[FAIL] %0t: ack rose while req low", $time));

  initial begin
    int               r;
    logic [`XLEN-1:0] word;
    logic [19:0]      imm20;
    logic [11:0]      imm12;
    rst   = 1'b1;
    req   = 1'b0;
    instr = '0;
    for (r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);
    // give every register a known value
    for (r = 1; r < 32; r++) begin
      imm20 = $random(seed);
      imm12 = $random(seed);
      run_transaction({imm20, r[4:0], rv_isa_pkg::LUI});
      run_transaction({imm12, r[4:0], 3'b000, r[4:0], rv_isa_pkg::OP_IMM});
    end
    for (r = 0; r < N_RAND; r++) begin
      random_word(word);
      run_transaction(word);
    end
    repeat (2) @(negedge clk);
    if (err_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_and_stop("checks reported errors during the run");
    end
  end

endmodule

//--- hw/rv_exec_top.sv
/*
 * Execute unit top level
 * issue controller, decoder, register file and ALU
 */
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_exec_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  rv_isa_pkg::instr_t   instr,
  output logic                 ack,
  output rv_core_pkg::commit_t commit
);

  rv_isa_pkg::instr_t   instr_q;
  rv_core_pkg::dec_op_t dec;
  logic [`XLEN-1:0]     rs1_data;
  logic [`XLEN-1:0]     rs2_data;
  logic [`XLEN-1:0]     result;
  logic                 wen;
  logic [`REG_AW-1:0]   waddr;
  logic [`XLEN-1:0]     wdata;

  rv_issue_ctrl u_ctrl (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .ack     (ack),
    .instr   (instr),
    .instr_q (instr_q),
    .dec     (dec),
    .result  (result),
    .wen     (wen),
    .waddr   (waddr),
    .wdata   (wdata),
    .commit  (commit)
  );

  rv_decoder u_dec (
    .instr (instr_q),
    .dec   (dec)
  );

  rv_regfile u_rf (
    .clk     (clk),
    .raddr_a (dec.rs1),
    .raddr_b (dec.rs2),
    .rdata_a (rs1_data),
    .rdata_b (rs2_data),
    .wen     (wen),
    .waddr   (waddr),
    .wdata   (wdata)
  );

  rv_alu u_alu (
    .op      (dec.alu_op),
    .use_imm (dec.use_imm),
    .a       (rs1_data),
    .b       (rs2_data),
    .imm     (dec.imm),
    .result  (result)
  );

endmodule

//--- hw/rv_issue_ctrl.sv
/*
 * Issue controller
 * four-phase req/ack FSM, instruction latch, write-back and commit record
 */
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_issue_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  output logic                 ack,
  input  rv_isa_pkg::instr_t   instr,
  output rv_isa_pkg::instr_t   instr_q,
  input  rv_core_pkg::dec_op_t dec,
  input  logic [`XLEN-1:0]     result,
  output logic                 wen,
  output logic [`REG_AW-1:0]   waddr,
  output logic [`XLEN-1:0]     wdata,
  output rv_core_pkg::commit_t commit
);

  rv_core_pkg::ctrl_state_e state;
  rv_core_pkg::ctrl_state_e state_nxt;
  logic                     accept;

  // new instructions are only taken in IDLE
  assign accept = req && (state == rv_core_pkg::IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      rv_core_pkg::IDLE:    if (req) state_nxt = rv_core_pkg::EXEC;
      rv_core_pkg::EXEC:    state_nxt = rv_core_pkg::HOLD;
      // back-pressure, wait for the host to drop req
      rv_core_pkg::HOLD:    if (!req) state_nxt = rv_core_pkg::RELEASE;
      rv_core_pkg::RELEASE: state_nxt = rv_core_pkg::IDLE;
      default:              state_nxt = rv_core_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= rv_core_pkg::IDLE;
      commit <= '0;
    end else begin
      state <= state_nxt;
      if (state == rv_core_pkg::EXEC) begin
        commit.rd      <= dec.rd;
        commit.wdata   <= result;
        commit.we      <= dec.we;
        commit.illegal <= dec.illegal;
      end
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      instr_q <= instr;
    end
  end

  assign ack   = (state == rv_core_pkg::HOLD);
  assign wen   = (state == rv_core_pkg::EXEC) && dec.we;
  assign waddr = dec.rd;
  assign wdata = result;

  // single write-back pulse per transaction
  a_wen_exec: assert property (
    @(posedge clk) disable iff (rst)
    wen |-> (state == rv_core_pkg::EXEC) ##1 !wen
  ) else $error("[FAIL] wen outside EXEC at %0t", $time);

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req)
  ) else $error("[FAIL] ack rose without req at %0t", $time);

  a_commit_stable: assert property (
    @(posedge clk) disable iff (rst)
    (ack && $past(ack)) |-> $stable(commit)
  ) else $error("[FAIL] commit changed under ack at %0t", $time);

endmodule

//--- hw/rv_alu.sv
/*
 * Integer ALU
 * operand b select, add/sub, logic, signed and unsigned compare, shifts
 */
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_alu (
  input  rv_core_pkg::alu_op_e op,
  input  logic                 use_imm,
  input  logic [`XLEN-1:0]     a,
  input  logic [`XLEN-1:0]     b,
  input  logic [`XLEN-1:0]     imm,
  output logic [`XLEN-1:0]     result
);

  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;

  // immediate forms replace rs2
  assign op_b  = use_imm ? imm : b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (op)
      rv_core_pkg::ADD:    result = a + op_b;
      rv_core_pkg::SUB:    result = a - op_b;
      rv_core_pkg::AND:    result = a & op_b;
      rv_core_pkg::OR:     result = a | op_b;
      rv_core_pkg::XOR:    result = a ^ op_b;
      rv_core_pkg::SLT: begin
        result = {{(`XLEN-1){1'b0}}, ($signed(a) < $signed(op_b))};
      end
      rv_core_pkg::SLTU: begin
        result = {{(`XLEN-1){1'b0}}, (a < op_b)};
      end
      rv_core_pkg::SLL:    result = a << shamt;
      rv_core_pkg::SRL:    result = a >> shamt;
      // arithmetic shift keeps the sign bit
      rv_core_pkg::SRA:    result = $unsigned($signed(a) >>> shamt);
      rv_core_pkg::PASS_B: result = op_b;
      default:             result = '0;
    endcase
  end

endmodule

//--- hw/rv_decoder.sv
/*
 * Instruction decoder
 * key-matched lookup of opcode, funct3 and funct7 into an ALU op,
 * immediate generation and illegal detection
 */
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_decoder (
  input  rv_isa_pkg::instr_t   instr,
  output rv_core_pkg::dec_op_t dec
);

  localparam int NR_KEY   = 16;
  localparam int KEY_LEN  = 17;
  localparam int DATA_LEN = 4;
  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // each pair is {opcode, funct3, funct7, alu_op}
  localparam logic [NR_KEY*PAIR_LEN-1:0] LUT = {
    rv_isa_pkg::OP,     rv_isa_pkg::F3_ADD_SUB, F7_BASE, rv_core_pkg::ADD,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_ADD_SUB, F7_ALT,  rv_core_pkg::SUB,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_AND,     F7_BASE, rv_core_pkg::AND,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_OR,      F7_BASE, rv_core_pkg::OR,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_XOR,     F7_BASE, rv_core_pkg::XOR,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_SLT,     F7_BASE, rv_core_pkg::SLT,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_SLTU,    F7_BASE, rv_core_pkg::SLTU,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_SLL,     F7_BASE, rv_core_pkg::SLL,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_SRL_SRA, F7_BASE, rv_core_pkg::SRL,
    rv_isa_pkg::OP,     rv_isa_pkg::F3_SRL_SRA, F7_ALT,  rv_core_pkg::SRA,
    rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD_SUB, F7_BASE, rv_core_pkg::ADD,
    rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_AND,     F7_BASE, rv_core_pkg::AND,
    rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_OR,      F7_BASE, rv_core_pkg::OR,
    rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_XOR,     F7_BASE, rv_core_pkg::XOR,
    rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_SLT,     F7_BASE, rv_core_pkg::SLT,
    rv_isa_pkg::LUI,    3'b000,                 F7_BASE, rv_core_pkg::PASS_B
  };

  logic                is_op;
  logic                is_lui;
  logic [KEY_LEN-1:0]  key;
  logic [DATA_LEN-1:0] sel;
  logic                hit;
  logic [`XLEN-1:0]    imm_i;
  logic [`XLEN-1:0]    imm_u;

  assign is_op  = (instr.opcode == rv_isa_pkg::OP);
  assign is_lui = (instr.opcode == rv_isa_pkg::LUI);

  // funct7 is immediate bits outside OP, funct3 too for LUI
  assign key = {instr.opcode,
                is_lui ? 3'b000 : instr.funct3,
                is_op ? instr.funct7 : 7'b0000000};

  // OR of all matching entries, at most one can hit
  always_comb begin
    sel = '0;
    hit = 1'b0;
    for (int i = 0; i < NR_KEY; i++) begin
      if (key == LUT[i*PAIR_LEN+DATA_LEN +: KEY_LEN]) begin
        sel = sel | LUT[i*PAIR_LEN +: DATA_LEN];
        hit = 1'b1;
      end
    end
  end

  // sign-extended bits 31:20
  assign imm_i = {{(`XLEN-12){instr.funct7[6]}}, instr.funct7, instr.rs2};
  // bits 31:12 with low 12 cleared
  assign imm_u = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'b0};

  always_comb begin
    dec.alu_op  = rv_core_pkg::alu_op_e'(sel);
    dec.rs1     = instr.rs1;
    dec.rs2     = instr.rs2;
    dec.rd      = instr.rd;
    dec.use_imm = !is_op;
    dec.imm     = is_lui ? imm_u : imm_i;
    dec.we      = hit && (instr.rd != '0);
    dec.illegal = !hit;
  end

endmodule

//--- hw/rv_regfile.sv
/*
 * Integer register file
 * two combinational read ports, one synchronous write port, x0 reads zero
 */
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_regfile (
  input  logic               clk,
  input  logic [`REG_AW-1:0] raddr_a,
  input  logic [`REG_AW-1:0] raddr_b,
  output logic [`XLEN-1:0]   rdata_a,
  output logic [`XLEN-1:0]   rdata_b,
  input  logic               wen,
  input  logic [`REG_AW-1:0] waddr,
  input  logic [`XLEN-1:0]   wdata
);

  localparam int DEPTH = 1 << `REG_AW;

  logic [`XLEN-1:0] regs [0:DEPTH-1];

  // x0 slot may hold junk, masked on read
  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

  // a write aimed at x0 must never show up on either port afterwards
  a_x0_zero: assert property (
    @(posedge clk)
    ((raddr_a != '0) || (rdata_a == '0)) && ((raddr_b != '0) || (rdata_b == '0))
  ) else $error("[FAIL] x0 read nonzero at %0t", $time);

endmodule

//--- common/rv_core_pkg.sv
/*
 * Micro-architecture types for the execute unit
 * ALU operations, decoded op, commit record, controller states
 */
`include "rv_macros.svh"

package rv_core_pkg;

  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    AND    = 4'd2,
    OR     = 4'd3,
    XOR    = 4'd4,
    SLT    = 4'd5,
    SLTU   = 4'd6,
    SLL    = 4'd7,
    SRL    = 4'd8,
    SRA    = 4'd9,
    PASS_B = 4'd10
  } alu_op_e;

  // decoder output, consumed by controller, register file and ALU
  typedef struct packed {
    alu_op_e            alu_op;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic               use_imm;
    logic [`XLEN-1:0]   imm;
    logic               we;
    logic               illegal;
  } dec_op_t;

  // what the host sees while ack is high
  typedef struct packed {
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   wdata;
    logic               we;
    logic               illegal;
  } commit_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    EXEC    = 2'd1,
    HOLD    = 2'd2,
    RELEASE = 2'd3
  } ctrl_state_e;

endpackage

//--- common/rv_isa_pkg.sv
/*
 * Instruction set types for the execute unit
 * major opcodes, ALU funct3 codes and the raw instruction fields
 */
`include "rv_macros.svh"

package rv_isa_pkg;

  // major opcodes handled by the unit
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // funct3 codes of the integer ALU group
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  // R-type field layout, msb first
  // kept as raw bits since the host may send any pattern
  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } instr_t;

endpackage

//--- common/rv_macros.svh
/*
 * Width macros shared by the execute unit
 * data path width and register address width
 */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_AW 5

`endif
